// File: verification/stream_fifo_cases.txt
// Columns, all hex: case id, beat count, input stall, output stall, expected
// Stall 0 none, 1 random, 2 output held low until full then released
// Expected: capacity when held, latency for one beat, output gap for a burst
// Zero beats runs a reset and checks the idle outputs
01 00 0 0 00
// One beat into an empty FIFO, out_valid one cycle after acceptance
02 01 0 0 01
// Full-rate burst, one beat per cycle
03 40 0 0 01
// Back-pressure, 16 beats held, then drained in order
04 18 0 2 10
// Random stalls on both sides
05 40 1 1 00
06 40 1 0 00
07 40 0 1 00
08 80 1 1 00
// Latency and throughput again after a busy FIFO
09 01 0 0 01
0a 30 0 0 01
// Back-pressure after wrap-around of the pointers
0b 20 0 2 10
0c 64 1 1 00
// Reset in the middle of the run, then traffic again
0d 00 0 0 00
0e 01 0 0 01
0f 11 0 2 10
10 c8 1 1 00

// File: build.f
common/stream_pkg.sv
rtl/mem_combinational.sv
rtl/stream_stage.sv
stream_fifo/stream_fifo.sv
rtl/stream_fifo_top.sv
verification/stream_fifo_props.sv
verification/stream_fifo_tb.sv

// File: Bender.yml
package:
  name: stream_fifo

sources:
  # Design
  - files:
      - common/stream_pkg.sv
      - rtl/mem_combinational.sv
      - rtl/stream_stage.sv
      - stream_fifo/stream_fifo.sv
      - rtl/stream_fifo_top.sv

  # Verification
  - target: test
    files:
      - verification/stream_fifo_props.sv
      - verification/stream_fifo_tb.sv

// File: verification/stream_fifo_tb.sv
/*
 * Stream FIFO subsystem testbench
 * Runs the cases of the case file against stream_fifo_top with LFSR data
 * and stalls, scoreboards every beat, checks latency, throughput and capacity
 */
`timescale 1ns/1ns

module stream_fifo_tb;

    // DUT ports
    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    logic                        in_ready;
    stream_pkg::stream_payload_t in_payload;
    logic                        out_valid;
    logic                        out_ready;
    stream_pkg::stream_payload_t out_payload;

    // Five hex words per case holding id, beats, input stall, output stall and expected
    logic [15:0] case_words [0:319];

    // Beats sent and not yet seen at the output with the oldest first
    stream_pkg::stream_payload_t sent_beats [$];

    logic [15:0] lfsr_state;
    int          case_errors;
    int          cases_passed;
    int          cases_failed;

    stream_fifo_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (in_payload),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_payload)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    // Random data with last on every fourth beat
    function automatic stream_pkg::stream_payload_t make_beat(input int index);
        stream_pkg::stream_payload_t beat;
        for (int i = 0; i < $bits(stream_pkg::data_t); i++) begin
            beat.data[i] = next_bit();
        end
        beat.last = (index % 4 == 3);
        return beat;
    endfunction

    // Reset held for 5 cycles and released 1 ns after an edge
    task automatic apply_reset();
        in_valid = 1'b0;
        out_ready = 1'b0;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Streams count beats with the given stalls until all have drained
    task automatic run_traffic(input int id, input int count, input int in_stall,
                               input int out_stall, input int expected);
        int                          limit;
        int                          edges;
        int                          sent;
        int                          received;
        int                          first_accept;
        int                          first_valid;
        int                          last_out;
        int                          max_gap;
        int                          blocked;
        logic                        fill_done;
        logic                        check_rise;
        logic                        in_fire;
        logic                        out_fire;
        logic                        done;
        stream_pkg::stream_payload_t seen;
        stream_pkg::stream_payload_t want;

        limit = count * 20 + 100;
        edges = 0;
        sent = 0;
        received = 0;
        first_accept = -1;
        first_valid = -1;
        last_out = 0;
        max_gap = 0;
        blocked = 0;
        fill_done = 1'b0;
        check_rise = 1'b0;
        done = 1'b0;
        sent_beats.delete();
        in_valid = 1'b0;
        out_ready = (out_stall == 0);

        for (int n = 0; n < limit && !done; n++) begin
            // Ready must be back right after the first held beat left
            if (check_rise) begin
                if (!in_ready) begin
                    $display("ERR t=%0t case %0d: in_ready still low after a beat left",
                             $time, id);
                    case_errors++;
                end
                check_rise = 1'b0;
            end
            // Fill phase with the output blocked
            if (out_stall == 2 && !fill_done) begin
                if (!in_ready) begin
                    blocked++;
                end else if (blocked > 0) begin
                    $display("ERR t=%0t case %0d: in_ready rose while full", $time, id);
                    case_errors++;
                end
                if (blocked >= 4 || sent == count) begin
                    fill_done = 1'b1;
                    if (sent != expected) begin
                        $display("ERR t=%0t case %0d: capacity %0d, expected %0d",
                                 $time, id, sent, expected);
                        case_errors++;
                    end
                    out_ready = 1'b1;
                end
            end
            if (out_stall == 1) begin
                out_ready = !next_bit();
            end
            // New beat only once the last one was taken
            if (!in_valid && sent < count && !(out_stall == 2 && fill_done)) begin
                if (in_stall == 0 || next_bit()) begin
                    in_payload = make_beat(sent);
                    in_valid = 1'b1;
                end
            end

            // Sample mid-cycle where everything has settled
            @(negedge clk);
            in_fire = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            seen = out_payload;
            if (out_valid && first_valid < 0) begin
                first_valid = edges;
            end
            @(posedge clk);
            #1;
            edges++;

            if (in_fire) begin
                sent_beats.push_back(in_payload);
                if (sent == 0) begin
                    first_accept = edges;
                end
                sent++;
                in_valid = 1'b0;
            end
            if (out_fire) begin
                if (sent_beats.size() == 0) begin
                    $display("Case %0d: a beat came out that was never sent", id);
                    case_errors++;
                end else begin
                    want = sent_beats.pop_front();
                    if (seen !== want) begin
                        $display("ERR t=%0t case %0d: beat %0d is %h last %b, expected %h last %b",
                                 $time, id, received, seen.data, seen.last,
                                 want.data, want.last);
                        case_errors++;
                    end
                end
                if (received > 0 && edges - last_out > max_gap) begin
                    max_gap = edges - last_out;
                end
                last_out = edges;
                received++;
                if (out_stall == 2 && received == 1) begin
                    check_rise = 1'b1;
                end
            end
            done = !in_valid && sent_beats.size() == 0 && (sent == count || fill_done);
        end

        if (!done) begin
            $display("Case %0d timed out: beats were still in flight after %0d cycles",
                     id, limit);
            case_errors++;
        end else begin
            if (out_valid) begin
                $display("ERR t=%0t case %0d: out_valid high on an empty FIFO", $time, id);
                case_errors++;
            end
            if (received != sent) begin
                $display("ERR t=%0t case %0d: %0d beats out, %0d in", $time, id, received, sent);
                case_errors++;
            end
            // Latency and throughput only hold without stalls
            if (out_stall == 0 && in_stall == 0 && count == 1) begin
                if (first_valid - first_accept != expected) begin
                    $display("ERR t=%0t case %0d: latency %0d, expected %0d",
                             $time, id, first_valid - first_accept, expected);
                    case_errors++;
                end
            end else if (out_stall == 0 && in_stall == 0) begin
                if (max_gap != expected) begin
                    $display("ERR t=%0t case %0d: largest output gap %0d, expected %0d",
                             $time, id, max_gap, expected);
                    case_errors++;
                end
            end
        end
        in_valid = 1'b0;
        out_ready = 1'b0;
    endtask

    // Zero beats means a reset check
    task automatic run_case(input int id, input int count, input int in_stall,
                            input int out_stall, input int expected);
        case_errors = 0;
        if (count == 0) begin
            apply_reset();
            @(negedge clk);
            if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                $display("ERR t=%0t case %0d: after reset out_valid %b in_ready %b",
                         $time, id, out_valid, in_ready);
                case_errors++;
            end
            @(posedge clk);
            #1;
        end else begin
            run_traffic(id, count, in_stall, out_stall, expected);
        end
        if (case_errors == 0) begin
            cases_passed++;
            $display("case %0d: ok", id);
        end else begin
            cases_failed++;
            $display("case %0d: FAILED with %0d errors", id, case_errors);
        end
    endtask

    initial begin
        int base;

        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        in_payload = '0;
        lfsr_state = 16'd57459;
        cases_passed = 0;
        cases_failed = 0;
        $readmemh("verification/stream_fifo_cases.txt", case_words);
        apply_reset();

        for (int c = 0; c < 64; c++) begin
            base = 5 * c;
            if (!$isunknown(case_words[base])) begin
                run_case(case_words[base], case_words[base + 1], case_words[base + 2],
                         case_words[base + 3], case_words[base + 4]);
            end
        end
        if (cases_passed + cases_failed == 0) begin
            $display("No cases were read from the case file");
            cases_failed++;
        end

        $display("Cases passed: %0d, failed: %0d, assertion failures: %0d",
                 cases_passed, cases_failed, dut0.props0.assert_failures);
        if (cases_failed == 0 && dut0.props0.assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verification/stream_fifo_props.sv
/*
 * Stream FIFO top-level properties
 * Reset state, valid/payload stability on both streams, no ready when full
 */
`timescale 1ns/1ns

module stream_fifo_props (
    input logic                        clk,
    input logic                        rst,
    input logic                        in_valid,
    input logic                        in_ready,
    input stream_pkg::stream_payload_t in_payload,
    input logic                        out_valid,
    input logic                        out_ready,
    input stream_pkg::stream_payload_t out_payload
);

    // Read back by the testbench
    int assert_failures = 0;

    // Beats inside the subsystem, memory plus output stage
    int occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(in_valid && in_ready) - int'(out_valid && out_ready);
        end
    end

    reset_clears_output: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            assert_failures++;
        end

    // Unaccepted input beat stays put
    input_held: assert property (@(posedge clk) disable iff (rst)
            (in_valid && !in_ready) |=> (in_valid && $stable(in_payload)))
        else begin
            $error("input beat dropped or changed before it was taken");
            assert_failures++;
        end

    output_held: assert property (@(posedge clk) disable iff (rst)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_payload)))
        else begin
            $error("output beat dropped or changed before it was taken");
            assert_failures++;
        end

    // DEPTH-1 in memory plus one in the stage
    no_ready_when_full: assert property (@(posedge clk) disable iff (rst)
            (occupancy == stream_pkg::FIFO_DEPTH && !out_ready) |-> !in_ready)
        else begin
            $error("in_ready high with the subsystem at capacity");
            assert_failures++;
        end

endmodule

bind stream_fifo_top stream_fifo_props props0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_payload  (in_payload),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_payload (out_payload)
);

// File: rtl/stream_fifo_top.sv
/*
 * Stream FIFO subsystem top level
 * One FIFO configured from the package, registered output, pointer addressing
 */
`timescale 1ns/1ns

module stream_fifo_top (
    input  logic                        clk,
    input  logic                        rst,

    // Input stream
    input  logic                        in_valid,
    output logic                        in_ready,
    input  stream_pkg::stream_payload_t in_payload,

    // Output stream
    output logic                        out_valid,
    input  logic                        out_ready,
    output stream_pkg::stream_payload_t out_payload
);

    // Capacity is FIFO_DEPTH-1 in memory plus one in the stage
    stream_fifo #(
        .ADDRESS_MODE  (stream_pkg::TOP_ADDRESS_MODE),
        .PIPELINE_MODE (stream_pkg::TOP_PIPELINE_MODE)
    ) stream_fifo_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_payload  (in_payload),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_payload)
    );

endmodule

// File: stream_fifo/stream_fifo.sv
/*
 * Valid/ready stream FIFO
 * Combinational-read memory followed by a stream stage, with occupancy
 * tracked either by read/write pointers or by one flag per entry
 */
`timescale 1ns/1ns

module stream_fifo #(
    parameter stream_pkg::stream_fifo_address_mode_t ADDRESS_MODE =
            stream_pkg::STREAM_FIFO_ADDRESS_MODE_POINTERS,
    parameter stream_pkg::stream_pipeline_mode_t PIPELINE_MODE =
            stream_pkg::STREAM_PIPELINE_MODE_REGISTERED
) (
    input  logic                        clk,
    input  logic                        rst,

    // Input stream
    input  logic                        in_valid,
    output logic                        in_ready,
    input  stream_pkg::stream_payload_t in_payload,

    // Output stream
    output logic                        out_valid,
    input  logic                        out_ready,
    output stream_pkg::stream_payload_t out_payload
);

    // Pointers and their successors
    stream_pkg::pointer_t read_pointer;
    stream_pkg::pointer_t write_pointer;
    stream_pkg::pointer_t read_pointer_next;
    stream_pkg::pointer_t write_pointer_next;

    // Occupancy status
    logic full;
    logic empty;

    // Handshake qualifiers
    logic write_enable;
    logic read_enable;

    // Internal stream from memory into the output stage
    logic                        next_valid;
    logic                        next_ready;
    stream_pkg::stream_payload_t next_payload;

    // Successors wrap at FIFO_DEPTH through the pointer width
    always_comb begin
        read_pointer_next = read_pointer + 1'b1;
        write_pointer_next = write_pointer + 1'b1;
    end

    // Ready only depends on state, never on out_ready
    always_comb begin
        in_ready = !full;
        write_enable = in_valid && in_ready;
        next_valid = !empty;
        read_enable = next_valid && next_ready;
    end

    // Read and write pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            read_pointer <= '0;
            write_pointer <= '0;
        end else begin
            if (read_enable) begin
                read_pointer <= read_pointer_next;
            end
            if (write_enable) begin
                write_pointer <= write_pointer_next;
            end
        end
    end

    generate
        if (ADDRESS_MODE == stream_pkg::STREAM_FIFO_ADDRESS_MODE_POINTERS) begin : g_pointers

            // One slot always left free, so DEPTH-1 entries
            always_comb begin
                full = (write_pointer_next == read_pointer);
                empty = (write_pointer == read_pointer);
            end

        end else begin : g_flags

            // One bit per memory entry, set while occupied
            stream_pkg::flag_t flags;

            always_ff @(posedge clk) begin
                if (rst) begin
                    flags <= '0;
                end else begin
                    // Read and write never hit the same entry in one cycle
                    if (read_enable) begin
                        flags[read_pointer] <= 1'b0;
                    end
                    if (write_enable) begin
                        flags[write_pointer] <= 1'b1;
                    end
                end
            end

            // All DEPTH entries usable
            always_comb begin
                full = flags[write_pointer];
                empty = !flags[read_pointer];
            end

        end
    endgenerate

    // Storage
    mem_combinational mem_combinational_inst (
        .clk          (clk),
        .write_enable (write_enable),
        .write_addr   (write_pointer),
        .write_data   (in_payload),
        .read_addr    (read_pointer),
        .read_data    (next_payload)
    );

    // Output stage, registered or transparent
    stream_stage #(
        .PIPELINE_MODE (PIPELINE_MODE)
    ) stream_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (next_valid),
        .in_ready    (next_ready),
        .in_payload  (next_payload),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_payload)
    );

endmodule

// File: rtl/stream_stage.sv
/*
 * Stream pipeline stage
 * Registered mode adds one cycle and launches data from flops,
 * transparent mode passes the stream straight through
 */
`timescale 1ns/1ns

module stream_stage #(
    parameter stream_pkg::stream_pipeline_mode_t PIPELINE_MODE =
            stream_pkg::STREAM_PIPELINE_MODE_REGISTERED
) (
    input  logic                        clk,
    input  logic                        rst,

    // Upstream side
    input  logic                        in_valid,
    output logic                        in_ready,
    input  stream_pkg::stream_payload_t in_payload,

    // Downstream side
    output logic                        out_valid,
    input  logic                        out_ready,
    output stream_pkg::stream_payload_t out_payload
);

    generate
        if (PIPELINE_MODE == stream_pkg::STREAM_PIPELINE_MODE_REGISTERED) begin : g_registered

            // Holding flag and payload register
            logic                        hold_valid;
            stream_pkg::stream_payload_t hold_payload;
            logic                        load;

            // Accept when empty or when the held beat leaves this cycle
            always_comb begin
                in_ready = !hold_valid || out_ready;
                load = in_valid && in_ready;
            end

            // Occupancy flag
            always_ff @(posedge clk) begin
                if (rst) begin
                    hold_valid <= 1'b0;
                end else if (load) begin
                    hold_valid <= 1'b1;
                end else if (out_ready) begin
                    // Beat left with nothing new behind it
                    hold_valid <= 1'b0;
                end
            end

            // Payload register
            always_ff @(posedge clk) begin
                if (load) begin
                    hold_payload <= in_payload;
                end
            end

            // Outputs straight from flops
            always_comb begin
                out_valid = hold_valid;
                out_payload = hold_payload;
            end

        end else begin : g_transparent

            // Zero latency pass-through
            // clk and rst are not needed here
            always_comb begin
                out_valid = in_valid;
                out_payload = in_payload;
                in_ready = out_ready;
            end

        end
    endgenerate

endmodule

// File: rtl/mem_combinational.sv
/*
 * Combinational-read memory
 * One write port on the clock edge, one read port with no clock cycle
 * penalty, distributed-RAM style storage for small FIFOs
 */
`timescale 1ns/1ns

module mem_combinational (
    input  logic                       clk,

    // Write port
    input  logic                       write_enable,
    input  stream_pkg::pointer_t       write_addr,
    input  stream_pkg::stream_payload_t write_data,

    // Read port
    input  stream_pkg::pointer_t       read_addr,
    output stream_pkg::stream_payload_t read_data
);

    // Storage array
    stream_pkg::stream_payload_t mem [stream_pkg::FIFO_DEPTH];

    // Write lands on the rising edge
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Read follows the address in the same cycle
    always_comb begin
        read_data = mem[read_addr];
    end

endmodule

// File: common/stream_pkg.sv
/*
 * Stream FIFO subsystem package
 * Beat payload type, storage widths and the mode enums shared by all blocks
 */
package stream_pkg;

    // Data word carried by each beat
    typedef logic [15:0] data_t;

    // One beat on any stream in the design, 17 bits wide
    typedef struct packed {
        data_t data;
        logic  last;
    } stream_payload_t;

    // Output stage behaviour of a FIFO or pipeline
    typedef enum logic {
        STREAM_PIPELINE_MODE_REGISTERED,
        STREAM_PIPELINE_MODE_TRANSPARENT
    } stream_pipeline_mode_t;

    // How the FIFO tracks occupancy
    typedef enum logic {
        STREAM_FIFO_ADDRESS_MODE_POINTERS,
        STREAM_FIFO_ADDRESS_MODE_FLAGS
    } stream_fifo_address_mode_t;

    // Storage size
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_POINTER_WIDTH = $clog2(FIFO_DEPTH);

    // Memory address and per-entry occupancy vector
    typedef logic [FIFO_POINTER_WIDTH-1:0] pointer_t;
    typedef logic [FIFO_DEPTH-1:0] flag_t;

    // Configuration picked by the top level
    localparam stream_fifo_address_mode_t TOP_ADDRESS_MODE = STREAM_FIFO_ADDRESS_MODE_POINTERS;
    localparam stream_pipeline_mode_t TOP_PIPELINE_MODE = STREAM_PIPELINE_MODE_REGISTERED;

endpackage
